/* build.f */
+incdir+include
design/icache_pkg.sv
design/sync_spram.sv
design/icache_refill.sv
design/icache_lookup.sv
design/icache_ctrl.sv
design/icache_fetch.sv
test/tb_mem_model.sv
test/tb_icache_fetch.sv

/* design/icache_ctrl.sv */
`timescale 1ns/1ns

module icache_ctrl #(
  parameter int WAY_CNT = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  icache_pkg::fetch_req_t        fetch_req_i,
  input  logic                          f1_stall_i,
  input  logic                          f2_stall_i,
  input  logic                          flush_i,
  input  logic                          cacheop_valid_i,
  input  logic [31:0]                   cacheop_addr_i,
  input  logic [WAY_CNT-1:0]            hit_i,
  input  logic                          miss_i,
  input  logic                          refill_done_i,
  output icache_pkg::refill_cmd_t       refill_cmd_o,
  output icache_pkg::tag_wr_t           tag_wr_o,
  output logic [icache_pkg::IIDX_LEN-1:0] rd_addr_o,
  output logic [31:0]                   f2_pc_o,
  output logic [1:0]                    valid_o,
  output logic [31:0]                   pc_o,
  output logic                          f2_stall_req_o
);

  localparam int IL = icache_pkg::IIDX_LEN;

  icache_pkg::fsm_state_t fsm_q, fsm_d;

  logic [1:0]   valid_q;
  logic         excp_q;
  logic         cop_q; // F2 holds an invalidate
  logic [31:0]  pc_q;
  logic [icache_pkg::TIDX_LEN-1:0] sweep_q;
  logic [WAY_CNT-1:0] victim_q;
  logic         refill_go;

  // F2 request registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
      excp_q  <= 1'b0;
      cop_q   <= 1'b0;
    end else if (flush_i) begin
      valid_q <= '0;
      excp_q  <= 1'b0;
      cop_q   <= 1'b0;
    end else if (!f2_stall_i) begin
      if (cacheop_valid_i) begin
        valid_q <= '0;
        excp_q  <= 1'b0;
        cop_q   <= 1'b1;
        pc_q    <= cacheop_addr_i;
      end else if (f1_stall_i) begin
        valid_q <= '0; // bubble
        excp_q  <= 1'b0;
        cop_q   <= 1'b0;
      end else begin
        valid_q <= fetch_req_i.valid;
        excp_q  <= fetch_req_i.excp;
        cop_q   <= 1'b0;
        pc_q    <= fetch_req_i.pc;
      end
    end else if (fsm_q == icache_pkg::S_INVAL) begin
      cop_q <= 1'b0; // op done, do not retrigger
    end
  end

  always_comb begin
    fsm_d = fsm_q;
    case (fsm_q)
      icache_pkg::S_IDLE: begin
        if (cop_q) begin
          fsm_d = icache_pkg::S_INVAL;
        end else if ((|valid_q) && !excp_q && miss_i) begin
          fsm_d = icache_pkg::S_REFILL;
        end
      end
      icache_pkg::S_SWEEP: begin
        if (&sweep_q) begin
          fsm_d = icache_pkg::S_IDLE;
        end
      end
      icache_pkg::S_INVAL:  fsm_d = icache_pkg::S_IDLE;
      icache_pkg::S_REFILL: begin
        if (refill_done_i) begin
          fsm_d = icache_pkg::S_REPLAY;
        end
      end
      icache_pkg::S_REPLAY: fsm_d = icache_pkg::S_IDLE;
      default:              fsm_d = icache_pkg::S_IDLE;
    endcase
  end

  assign refill_go = (fsm_q == icache_pkg::S_IDLE) && (fsm_d == icache_pkg::S_REFILL);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fsm_q    <= icache_pkg::S_SWEEP;
      sweep_q  <= '0;
      victim_q <= WAY_CNT'(1);
    end else begin
      fsm_q <= fsm_d;
      if (fsm_q == icache_pkg::S_SWEEP) begin
        sweep_q <= sweep_q + 1'b1;
      end
      if (refill_go) begin
        // rotate one-hot victim
        victim_q <= (victim_q << 1) | (victim_q >> (WAY_CNT - 1));
      end
    end
  end

  always_comb begin
    refill_cmd_o           = '0;
    refill_cmd_o.start     = refill_go;
    refill_cmd_o.line_addr = {pc_q[31:4], 4'b0000};
    refill_cmd_o.way[WAY_CNT-1:0] = victim_q;
  end

  // tag writes: sweep clear, new line, invalidate
  always_comb begin
    tag_wr_o             = '0;
    tag_wr_o.idx         = pc_q[IL-1:4];
    tag_wr_o.entry.tag   = pc_q[31:IL];
    if (fsm_q == icache_pkg::S_SWEEP) begin
      tag_wr_o.we[WAY_CNT-1:0] = '1;
      tag_wr_o.idx             = sweep_q;
      tag_wr_o.entry           = '0;
    end else if (refill_go) begin
      tag_wr_o.we[WAY_CNT-1:0] = victim_q;
      tag_wr_o.entry.valid     = 1'b1;
    end else if (fsm_q == icache_pkg::S_INVAL) begin
      tag_wr_o.we[WAY_CNT-1:0] = hit_i;
      tag_wr_o.entry           = '0;
    end
  end

  // hold the F2 address on the arrays while stalled
  always_comb begin
    if (f2_stall_req_o || f2_stall_i) begin
      rd_addr_o = pc_q[IL-1:0];
    end else if (cacheop_valid_i) begin
      rd_addr_o = cacheop_addr_i[IL-1:0];
    end else begin
      rd_addr_o = fetch_req_i.pc[IL-1:0];
    end
  end

  assign f2_pc_o        = pc_q;
  assign pc_o           = pc_q;
  assign valid_o        = valid_q & {2{!f2_stall_i}};
  assign f2_stall_req_o = (fsm_q != icache_pkg::S_IDLE) || (fsm_d != icache_pkg::S_IDLE);

endmodule

/* design/icache_fetch.sv */
`timescale 1ns/1ns

module icache_fetch #(
  parameter int WAY_CNT        = 2,
  parameter int ATTACHED_WIDTH = 32
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  icache_pkg::fetch_req_t    fetch_req_i,
  input  logic [ATTACHED_WIDTH-1:0] attached_i,
  input  logic                      f1_stall_i,
  input  logic                      f2_stall_i,
  input  logic                      flush_i,
  input  logic                      cacheop_valid_i,
  input  logic [31:0]               cacheop_addr_i,
  input  icache_pkg::bus_resp_t     bus_resp_i,
  output logic [1:0]                valid_o,
  output icache_pkg::iline_grp_t    inst_o,
  output logic [31:0]               pc_o,
  output logic [ATTACHED_WIDTH-1:0] attached_o,
  output logic                      f2_stall_req_o,
  output icache_pkg::bus_req_t      bus_req_o
);

  icache_pkg::refill_cmd_t          refill_cmd;
  icache_pkg::tag_wr_t              tag_wr;
  logic [icache_pkg::IIDX_LEN-1:0]  rd_addr;
  logic [31:0]                      f2_pc;
  logic [WAY_CNT-1:0]               hit;
  logic                             miss;
  logic                             refill_done;
  logic [icache_pkg::MAX_WAYS-1:0]  data_we;
  logic [icache_pkg::DADDR_LEN-1:0] data_waddr;
  logic [31:0]                      data_wdata;
  icache_pkg::iline_grp_t           grp;
  logic                             grp_valid;

  icache_ctrl #(.WAY_CNT(WAY_CNT)) i_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_req_i     (fetch_req_i),
    .f1_stall_i      (f1_stall_i),
    .f2_stall_i      (f2_stall_i),
    .flush_i         (flush_i),
    .cacheop_valid_i (cacheop_valid_i),
    .cacheop_addr_i  (cacheop_addr_i),
    .hit_i           (hit),
    .miss_i          (miss),
    .refill_done_i   (refill_done),
    .refill_cmd_o    (refill_cmd),
    .tag_wr_o        (tag_wr),
    .rd_addr_o       (rd_addr),
    .f2_pc_o         (f2_pc),
    .valid_o         (valid_o),
    .pc_o            (pc_o),
    .f2_stall_req_o  (f2_stall_req_o)
  );

  icache_refill i_refill (
    .clk           (clk),
    .rst_n         (rst_n),
    .refill_cmd_i  (refill_cmd),
    .f2_pc_i       (f2_pc),
    .bus_resp_i    (bus_resp_i),
    .bus_req_o     (bus_req_o),
    .data_we_o     (data_we),
    .data_waddr_o  (data_waddr),
    .data_wdata_o  (data_wdata),
    .grp_o         (grp),
    .grp_valid_o   (grp_valid),
    .refill_done_o (refill_done)
  );

  icache_lookup #(.WAY_CNT(WAY_CNT)) i_lookup (
    .clk                (clk),
    .rst_n              (rst_n),
    .rd_addr_i          (rd_addr),
    .f2_stall_i         (f2_stall_i),
    .cmp_pc_i           (f2_pc),
    .tag_wr_i           (tag_wr),
    .data_we_i          (data_we),
    .data_waddr_i       (data_waddr),
    .data_wdata_i       (data_wdata),
    .refill_grp_i       (grp),
    .refill_grp_valid_i (grp_valid),
    .hit_o              (hit),
    .miss_o             (miss),
    .inst_o             (inst_o)
  );

  // side info follows the group into F2
  always_ff @(posedge clk) begin
    if (!f2_stall_i) begin
      attached_o <= attached_i;
    end
  end

endmodule

/* design/icache_lookup.sv */
`timescale 1ns/1ns

module icache_lookup #(
  parameter int WAY_CNT = 2
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [icache_pkg::IIDX_LEN-1:0]  rd_addr_i,
  input  logic                             f2_stall_i,
  input  logic [31:0]                      cmp_pc_i,
  input  icache_pkg::tag_wr_t              tag_wr_i,
  input  logic [icache_pkg::MAX_WAYS-1:0]  data_we_i,
  input  logic [icache_pkg::DADDR_LEN-1:0] data_waddr_i,
  input  logic [31:0]                      data_wdata_i,
  input  icache_pkg::iline_grp_t           refill_grp_i,
  input  logic                             refill_grp_valid_i,
  output logic [WAY_CNT-1:0]               hit_o,
  output logic                             miss_o,
  output icache_pkg::iline_grp_t           inst_o
);

  localparam int IL = icache_pkg::IIDX_LEN;

  icache_pkg::itag_t      tag_rd  [WAY_CNT];
  icache_pkg::iline_grp_t data_rd [WAY_CNT];
  icache_pkg::iline_grp_t sel_data;
  icache_pkg::iline_grp_t skid_q;
  logic                   f2_stall_q;
  logic                   data_wr;

  assign data_wr = |data_we_i;

  for (genvar w = 0; w < WAY_CNT; w++) begin : g_way
    logic [icache_pkg::TIDX_LEN-1:0]  taddr;
    logic [icache_pkg::DADDR_LEN-2:0] daddr;
    logic [1:0]                       dwe;

    assign taddr = tag_wr_i.we[w] ? tag_wr_i.idx : rd_addr_i[IL-1:4];
    assign daddr = data_wr ? data_waddr_i[icache_pkg::DADDR_LEN-1:1] : rd_addr_i[IL-1:3];
    assign dwe   = {data_we_i[w] && data_waddr_i[0], data_we_i[w] && !data_waddr_i[0]};

    sync_spram #(
      .DATA_T (icache_pkg::itag_t),
      .DEPTH  (1 << icache_pkg::TIDX_LEN),
      .LANES  (1)
    ) i_tag_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .addr_i  (taddr),
      .we_i    (tag_wr_i.we[w]),
      .wdata_i (tag_wr_i.entry),
      .rdata_o (tag_rd[w])
    );

    sync_spram #(
      .DATA_T (icache_pkg::iline_grp_t),
      .DEPTH  (1 << (icache_pkg::DADDR_LEN - 1)),
      .LANES  (2)
    ) i_data_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .addr_i  (daddr),
      .we_i    (dwe),
      .wdata_i ({data_wdata_i, data_wdata_i}),
      .rdata_o (data_rd[w])
    );

    assign hit_o[w] = tag_rd[w].valid && (tag_rd[w].tag == cmp_pc_i[31:IL]);
  end

  assign miss_o = ~|hit_o;

  always_comb begin
    sel_data = '0;
    for (int w = 0; w < WAY_CNT; w++) begin
      if (hit_o[w]) begin
        sel_data |= data_rd[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      f2_stall_q <= 1'b0;
    end else begin
      f2_stall_q <= f2_stall_i;
    end
  end

  // refill group wins over the held output
  always_ff @(posedge clk) begin
    if (refill_grp_valid_i) begin
      skid_q <= refill_grp_i;
    end else if (!f2_stall_q) begin
      skid_q <= inst_o;
    end
  end

  assign inst_o = f2_stall_q ? skid_q : sel_data;

endmodule

/* design/icache_pkg.sv */
package icache_pkg;

  `include "icache_cfg.svh"

  localparam int IIDX_LEN   = `ICACHE_IIDX_LEN;
  localparam int ITAG_LEN   = `ICACHE_ITAG_LEN;
  localparam int LINE_WORDS = `ICACHE_LINE_WORDS;
  localparam int MAX_WAYS   = 4;
  localparam int TIDX_LEN   = IIDX_LEN - 4; // line index, 256 sets
  localparam int DADDR_LEN  = IIDX_LEN - 2; // word address into a way

  typedef struct packed {
    logic                valid;
    logic [ITAG_LEN-1:0] tag;
  } itag_t;

  typedef logic [1:0][31:0] iline_grp_t; // two aligned instructions

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [3:0]  burst_size; // beats minus one
    logic        data_ok;
  } bus_req_t;

  typedef struct packed {
    logic        ready;
    logic        data_ok;
    logic        data_last;
    logic [31:0] r_data;
  } bus_resp_t;

  typedef struct packed {
    logic [1:0]  valid;
    logic [31:0] pc;
    logic        excp;
  } fetch_req_t;

  typedef enum logic [4:0] {
    S_IDLE   = 5'b00001,
    S_SWEEP  = 5'b00010,
    S_INVAL  = 5'b00100,
    S_REFILL = 5'b01000,
    S_REPLAY = 5'b10000
  } fsm_state_t;

  typedef struct packed {
    logic                start;
    logic [31:0]         line_addr;
    logic [MAX_WAYS-1:0] way; // one-hot, upper bits zero
  } refill_cmd_t;

  typedef struct packed {
    logic [MAX_WAYS-1:0] we;
    logic [TIDX_LEN-1:0] idx;
    itag_t               entry;
  } tag_wr_t;

endpackage

/* design/icache_refill.sv */
`timescale 1ns/1ns

module icache_refill (
  input  logic                             clk,
  input  logic                             rst_n,
  input  icache_pkg::refill_cmd_t          refill_cmd_i,
  input  logic [31:0]                      f2_pc_i,
  input  icache_pkg::bus_resp_t            bus_resp_i,
  output icache_pkg::bus_req_t             bus_req_o,
  output logic [icache_pkg::MAX_WAYS-1:0]  data_we_o,
  output logic [icache_pkg::DADDR_LEN-1:0] data_waddr_o,
  output logic [31:0]                      data_wdata_o,
  output icache_pkg::iline_grp_t           grp_o,
  output logic                             grp_valid_o,
  output logic                             refill_done_o
);

  localparam int IL = icache_pkg::IIDX_LEN;

  logic        req_q;  // address phase
  logic        recv_q; // data phase
  logic [31:0] addr_q;
  logic [icache_pkg::MAX_WAYS-1:0] way_q;
  logic [1:0]  cnt_q;
  logic        beat;
  logic        wr_q;
  logic        done_q;
  logic [icache_pkg::DADDR_LEN-1:0] waddr_q;
  logic [31:0] wdata_q;
  icache_pkg::iline_grp_t grp_q;

  assign beat = recv_q && bus_resp_i.data_ok;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q  <= 1'b0;
      recv_q <= 1'b0;
      cnt_q  <= '0;
      wr_q   <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (refill_cmd_i.start) begin
        req_q <= 1'b1;
      end else if (req_q && bus_resp_i.ready) begin
        req_q  <= 1'b0;
        recv_q <= 1'b1;
      end
      if (beat) begin
        cnt_q <= cnt_q + 1'b1;
        if (bus_resp_i.data_last) begin
          recv_q <= 1'b0;
          cnt_q  <= '0;
        end
      end
      wr_q   <= beat;
      done_q <= beat && bus_resp_i.data_last;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (refill_cmd_i.start) begin
      addr_q <= refill_cmd_i.line_addr;
      way_q  <= refill_cmd_i.way;
    end
    if (beat) begin
      waddr_q <= {addr_q[IL-1:4], cnt_q};
      wdata_q <= bus_resp_i.r_data;
      if (cnt_q[1] == f2_pc_i[3]) begin
        grp_q[cnt_q[0]] <= bus_resp_i.r_data; // requested group
      end
    end
  end

  always_comb begin
    bus_req_o            = '0;
    bus_req_o.valid      = req_q;
    bus_req_o.addr       = addr_q;
    bus_req_o.burst_size = 4'd3;
    bus_req_o.data_ok    = recv_q;
  end

  assign data_we_o     = way_q & {icache_pkg::MAX_WAYS{wr_q}};
  assign data_waddr_o  = waddr_q;
  assign data_wdata_o  = wdata_q;
  assign grp_o         = grp_q;
  assign grp_valid_o   = done_q;
  assign refill_done_o = done_q; // same cycle as last write

endmodule

/* design/sync_spram.sv */
`timescale 1ns/1ns

module sync_spram #(
  parameter type DATA_T = logic [31:0],
  parameter int  DEPTH  = 256,
  parameter int  LANES  = 1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic [LANES-1:0]         we_i,
  input  DATA_T                    wdata_i,
  output DATA_T                    rdata_o
);

  localparam int W  = $bits(DATA_T);
  localparam int LW = W / LANES;

  logic [W-1:0] mem [DEPTH];
  logic [W-1:0] wbits;
  logic [W-1:0] rd_q;

  assign wbits = wdata_i;

  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      if (we_i[l]) begin
        mem[addr_i][l*LW +: LW] <= wbits[l*LW +: LW];
      end
    end
  end

  // read returns the old word on a write to the same address
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_q <= '0;
    end else begin
      rd_q <= mem[addr_i];
    end
  end

  assign rdata_o = DATA_T'(rd_q);

endmodule

/* include/icache_cfg.svh */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// index plus byte offset within a way
`define ICACHE_IIDX_LEN 12

// physical tag above the index
`define ICACHE_ITAG_LEN 20

// 32-bit words per cache line
`define ICACHE_LINE_WORDS 4

`endif

/* test/tb_icache_fetch.sv */
`timescale 1ns/1ns

module tb_icache_fetch;

  localparam logic [31:0] SEED       = 32'hcade75c4;
  localparam logic [31:0] MEM_KEY    = 32'h5a5a0000;
  localparam int          SWEEP_LEN  = 256;
  localparam int          WAIT_LIMIT = 1000;
  // about fourteen fetches and ops, each bounded by one wait, sweep in the slack
  localparam int          TIMEOUT_CYCLES = 20 * WAIT_LIMIT;

  // three lines sharing index 0x12, one spare line
  localparam logic [31:0] LINE_A = 32'h0001_0120;
  localparam logic [31:0] LINE_B = 32'h0002_0120;
  localparam logic [31:0] LINE_C = 32'h0003_0120;
  localparam logic [31:0] LINE_D = 32'h0000_0300;

  logic                   clk = 1'b0;
  logic                   rst_n;
  icache_pkg::fetch_req_t fetch_req;
  logic [31:0]            attached_in;
  logic                   f1_stall;
  logic                   f2_stall = 1'b0;
  logic                   flush;
  logic                   cacheop_valid;
  logic [31:0]            cacheop_addr;
  icache_pkg::bus_resp_t  bus_resp;
  logic [1:0]             valid;
  icache_pkg::iline_grp_t inst;
  logic [31:0]            pc;
  logic [31:0]            attached_out;
  logic                   stall_req;
  icache_pkg::bus_req_t   bus_req;
  int                     req_count;

  logic hold_stall;
  int   errors = 0;
  int   tests_failed = 0;
  int   valid_seen = 0;
  int   cycle_cnt = 0;

  always #4 clk = ~clk;

  icache_fetch #(
    .WAY_CNT        (2),
    .ATTACHED_WIDTH (32)
  ) i_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_req_i     (fetch_req),
    .attached_i      (attached_in),
    .f1_stall_i      (f1_stall),
    .f2_stall_i      (f2_stall),
    .flush_i         (flush),
    .cacheop_valid_i (cacheop_valid),
    .cacheop_addr_i  (cacheop_addr),
    .bus_resp_i      (bus_resp),
    .valid_o         (valid),
    .inst_o          (inst),
    .pc_o            (pc),
    .attached_o      (attached_out),
    .f2_stall_req_o  (stall_req),
    .bus_req_o       (bus_req)
  );

  tb_mem_model #(.SEED(SEED)) i_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus_req_i   (bus_req),
    .bus_resp_o  (bus_resp),
    .req_count_o (req_count)
  );

  // front end honours the stall request
  always @(negedge clk) f2_stall <= stall_req || hold_stall;

  function automatic logic [31:0] expected_word(input logic [31:0] byte_addr);
    return (byte_addr >> 2) ^ MEM_KEY;
  endfunction

  task automatic flag_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic flag_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  // every presented group must follow the memory rule
  always @(posedge clk) begin
    if (rst_n && valid != 2'b00) begin
      valid_seen++;
      for (int s = 0; s < 2; s++) begin
        if (valid[s]) begin
          assert (inst[s] == expected_word({pc[31:3], 3'b000} + 32'(4 * s)))
          else flag_mismatch($sformatf("slot %0d of pc %h is %h, expected %h", s, pc, inst[s],
                                       expected_word({pc[31:3], 3'b000} + 32'(4 * s))));
        end
      end
    end
  end

  // each bus request asks for one aligned line in four beats
  always @(posedge clk) begin
    if (rst_n && bus_req.valid) begin
      assert (bus_req.burst_size == 4'd3 && bus_req.addr[3:0] == 4'h0)
      else flag_mismatch($sformatf("bus request at %h with burst_size %0d", bus_req.addr,
                                   bus_req.burst_size));
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // next falling edge without a stall request
  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (stall_req && n < WAIT_LIMIT) begin
      n++;
      @(negedge clk);
    end
    if (stall_req) begin
      flag_failure("stall request never dropped");
    end
  endtask

  task automatic fetch_expect(input logic [31:0] addr, input int exp_reqs);
    int c0;
    int lat;
    int reqs;
    wait_idle();
    c0              = req_count;
    fetch_req.valid = 2'b11;
    fetch_req.pc    = addr;
    attached_in     = ~addr;
    @(posedge clk);
    @(negedge clk);
    fetch_req.valid = 2'b00;
    attached_in     = addr; // must not reach a stalled F2
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (valid == 2'b00 && lat < WAIT_LIMIT);
    if (valid == 2'b00) begin
      flag_failure($sformatf("no valid group for pc %h within %0d cycles", addr, WAIT_LIMIT));
    end
    assert (pc == addr)
    else flag_mismatch($sformatf("pc_o %h, expected %h", pc, addr));
    assert (attached_out == ~addr)
    else flag_mismatch($sformatf("attached %h with pc %h", attached_out, addr));
    @(negedge clk);
    reqs = req_count - c0;
    assert (reqs == exp_reqs)
    else flag_mismatch($sformatf("pc %h made %0d bus requests, expected %0d", addr, reqs,
                                 exp_reqs));
    if (exp_reqs == 0) begin
      assert (lat == 1)
      else flag_mismatch($sformatf("hit on pc %h took %0d cycles", addr, lat));
    end
  endtask

  task automatic invalidate_line(input logic [31:0] addr, output int stall_len);
    wait_idle();
    cacheop_valid = 1'b1;
    cacheop_addr  = addr;
    @(posedge clk);
    @(negedge clk);
    cacheop_valid = 1'b0;
    stall_len = 0;
    while (stall_req && stall_len < WAIT_LIMIT) begin
      stall_len++;
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: fail, %0d errors", num, name, errors - err_before);
      tests_failed++;
    end
  endtask

  initial begin : stimulus
    int n;
    int e0;
    int v0;
    icache_pkg::iline_grp_t grp;
    rst_n         = 1'b0;
    fetch_req     = '0;
    attached_in   = '0;
    f1_stall      = 1'b0;
    flush         = 1'b0;
    cacheop_valid = 1'b0;
    cacheop_addr  = '0;
    hold_stall    = 1'b0;

    e0 = errors;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    n = 0;
    while (stall_req && n <= SWEEP_LEN) begin
      assert (valid == 2'b00 && !bus_req.valid && !bus_req.data_ok)
      else flag_mismatch("output or bus active during the tag sweep");
      n++;
      @(negedge clk);
    end
    assert (n == SWEEP_LEN)
    else flag_mismatch($sformatf("sweep stall lasted %0d cycles, expected %0d", n, SWEEP_LEN));
    fetch_expect(32'h0000_0048, 1);
    finish_test(1, "reset sweep", e0);

    e0 = errors;
    fetch_expect(32'h0000_0200, 1);
    fetch_expect(32'h0000_0208, 0); // other group, same line
    finish_test(2, "miss then hit", e0);

    e0 = errors;
    fetch_expect(LINE_A, 1);
    fetch_expect(LINE_B, 1);
    fetch_expect(LINE_C, 1); // evicts A
    fetch_expect(LINE_B, 0);
    fetch_expect(LINE_A, 1);
    finish_test(3, "replacement", e0);

    e0 = errors;
    invalidate_line(LINE_C, n);
    assert (n == 2)
    else flag_mismatch($sformatf("invalidate stalled %0d cycles, expected 2", n));
    fetch_expect(LINE_A, 0);
    fetch_expect(LINE_C, 1);
    finish_test(4, "invalidate", e0);

    e0 = errors;
    wait_idle();
    n               = req_count;
    v0              = valid_seen;
    fetch_req.valid = 2'b11;
    fetch_req.pc    = LINE_D;
    @(posedge clk);
    @(negedge clk);
    fetch_req.valid = 2'b00;
    flush           = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    wait_idle();
    repeat (2) @(negedge clk);
    assert (valid_seen == v0)
    else flag_mismatch("a group was shown after the flush");
    assert (req_count == n + 1)
    else flag_mismatch($sformatf("flushed miss made %0d requests", req_count - n));
    fetch_expect(LINE_D, 0); // burst still filled the line
    finish_test(5, "flush", e0);

    e0 = errors;
    grp[0] = expected_word(32'h0000_0208);
    grp[1] = expected_word(32'h0000_020c);
    wait_idle();
    fetch_req.valid = 2'b11;
    fetch_req.pc    = 32'h0000_0208;
    attached_in     = 32'h0a77_0006;
    @(posedge clk);
    hold_stall = 1'b1;
    @(negedge clk);
    fetch_req.valid = 2'b00;
    fetch_req.pc    = LINE_A;
    attached_in     = 32'hffff_0000;
    repeat (6) begin
      @(posedge clk);
      assert (valid == 2'b00 && inst == grp && pc == 32'h0000_0208 &&
              attached_out == 32'h0a77_0006)
      else flag_mismatch($sformatf("F2 moved under stall: valid %b pc %h attached %h",
                                   valid, pc, attached_out));
    end
    hold_stall = 1'b0;
    @(posedge clk);
    assert (valid == 2'b11 && attached_out == 32'h0a77_0006)
    else flag_mismatch($sformatf("held group lost on release: valid %b attached %h",
                                 valid, attached_out));
    finish_test(6, "stall hold", e0);

    $display("summary: 6 tests, %0d failed, %0d errors", tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/1ns

module tb_mem_model #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  icache_pkg::bus_req_t  bus_req_i,
  output icache_pkg::bus_resp_t bus_resp_o,
  output int                    req_count_o
);

  localparam logic [31:0] WORD_KEY = 32'h5a5a0000;

  integer      seed;
  logic        busy_q;
  logic [31:0] base_q;
  logic [1:0]  beat_q;

  initial seed = SEED;

  // address and beat handshakes seen on the rising edge
  always @(posedge clk) begin
    if (!rst_n) begin
      busy_q      <= 1'b0;
      beat_q      <= '0;
      req_count_o <= 0;
    end else if (!busy_q) begin
      if (bus_req_i.valid && bus_resp_o.ready) begin
        busy_q      <= 1'b1;
        base_q      <= bus_req_i.addr;
        beat_q      <= '0;
        req_count_o <= req_count_o + 1;
      end
    end else if (bus_resp_o.data_ok && bus_req_i.data_ok) begin
      beat_q <= beat_q + 1'b1;
      if (bus_resp_o.data_last) begin
        busy_q <= 1'b0; // burst done
      end
    end
  end

  // falling edge drive, ready and beats with random gaps
  initial begin : drive
    icache_pkg::bus_resp_t resp;
    bus_resp_o = '0;
    forever begin
      @(negedge clk);
      resp = '0;
      if (rst_n && !busy_q) begin
        resp.ready = bus_req_i.valid && (($random(seed) & 3) != 0);
      end else if (rst_n) begin
        resp.data_ok   = ($random(seed) & 3) != 0;
        resp.data_last = (beat_q == 2'd3);
        resp.r_data    = ((base_q >> 2) + beat_q) ^ WORD_KEY; // word address rule
      end
      bus_resp_o <= resp;
    end
  end

endmodule
